//--- source/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

    // master side data bus
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;

    // region select lives in the top nibble of the address
    localparam int REGION_W = 4;

    localparam logic [REGION_W-1:0] REGION_RAM_BASE    = 4'h0;
    localparam logic [REGION_W-1:0] REGION_GPIO_BASE   = 4'h1;
    localparam logic [REGION_W-1:0] REGION_TICKER_BASE = 4'h2;

    typedef enum logic [1:0] {
        REGION_RAM,
        REGION_GPIO,
        REGION_TICKER,
        REGION_NONE     // any other top nibble
    } region_e;

endpackage

`default_nettype wire

//--- source/soc_apb_pkg.sv
`default_nettype none

package soc_apb_pkg;

    localparam int APB_ADDR_W = 8;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS,
        APB_DONE
    } apb_state_e;

    // gpio register offsets
    localparam logic [APB_ADDR_W-1:0] GPIO_OUT_OFS = 8'h00;
    localparam logic [APB_ADDR_W-1:0] GPIO_IN_OFS  = 8'h04;   // read only

    // ticker register offsets
    localparam logic [APB_ADDR_W-1:0] TICK_COUNT_OFS = 8'h00;  // read only
    localparam logic [APB_ADDR_W-1:0] TICK_CMP_OFS   = 8'h04;  // 0 disables compare
    localparam logic [APB_ADDR_W-1:0] TICK_STAT_OFS  = 8'h08;  // bit 0 irq flag

endpackage

`default_nettype wire

//--- source/apb_if.sv
`default_nettype none

interface apb_if #(
    parameter int DATA_W = 32
);

    logic [soc_apb_pkg::APB_ADDR_W-1:0] paddr;
    logic                               psel;
    logic                               penable;
    logic                               pwrite;
    logic [DATA_W-1:0]                  pwdata;
    logic [DATA_W/8-1:0]                pstrb;
    logic [DATA_W-1:0]                  prdata;
    logic                               pready;

    modport master (
        output paddr, psel, penable, pwrite, pwdata, pstrb,
        input  prdata, pready
    );

    modport slave (
        input  paddr, psel, penable, pwrite, pwdata, pstrb,
        output prdata, pready
    );

endinterface

`default_nettype wire

//--- source/ram_if.sv
`default_nettype none

interface ram_if #(
    parameter int ADDR_BITS = 8,
    parameter int DATA_W    = 32
);

    logic [ADDR_BITS-1:0] addr;     // word address
    logic [DATA_W/8-1:0]  be;
    logic [DATA_W-1:0]    wdata;
    logic                 rd;
    logic                 wr;
    logic [DATA_W-1:0]    rdata;

    modport ctrl (output addr, be, wdata, rd, wr, input rdata);
    modport mem  (input addr, be, wdata, rd, wr, output rdata);

endinterface

`default_nettype wire

//--- source/dbus_decoder.sv
`default_nettype none

module dbus_decoder #(
    parameter int RAM_ADDR_BITS = 8
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire [soc_bus_pkg::ADDR_W-1:0]       master_address_i,
    input  wire [soc_bus_pkg::BE_W-1:0]         master_byteenable_i,
    input  wire                                 master_read_i,
    input  wire                                 master_write_i,
    input  wire [soc_bus_pkg::DATA_W-1:0]       master_wrdata_i,
    output logic [soc_bus_pkg::DATA_W-1:0]      master_rddata_o,
    output logic                                master_stall_o,
    input  wire [soc_bus_pkg::DATA_W-1:0]       bridge_rdata_i,
    input  wire                                 bridge_stall_i,
    output soc_bus_pkg::region_e                bridge_region_o,
    output logic                                bridge_read_o,
    output logic                                bridge_write_o,
    ram_if.ctrl                                 ram
);

    soc_bus_pkg::region_e region;
    logic is_ram;
    logic is_apb;
    logic ram_rd;
    logic rd_pend_q;    // ram read issued last cycle

    always_comb begin
        case (master_address_i[soc_bus_pkg::ADDR_W-1 -: soc_bus_pkg::REGION_W])
            soc_bus_pkg::REGION_RAM_BASE:    region = soc_bus_pkg::REGION_RAM;
            soc_bus_pkg::REGION_GPIO_BASE:   region = soc_bus_pkg::REGION_GPIO;
            soc_bus_pkg::REGION_TICKER_BASE: region = soc_bus_pkg::REGION_TICKER;
            default:                         region = soc_bus_pkg::REGION_NONE;
        endcase
    end

    assign is_ram = (region == soc_bus_pkg::REGION_RAM);
    assign is_apb = (region == soc_bus_pkg::REGION_GPIO) ||
                    (region == soc_bus_pkg::REGION_TICKER);

    // only the first cycle of a read goes to the ram
    assign ram_rd = master_read_i & is_ram & ~rd_pend_q;

    assign ram.addr  = master_address_i[RAM_ADDR_BITS+1:2];
    assign ram.be    = master_byteenable_i;
    assign ram.wdata = master_wrdata_i;
    assign ram.rd    = ram_rd;
    assign ram.wr    = master_write_i & is_ram;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= ram_rd;
        end
    end

    assign bridge_region_o = region;
    assign bridge_read_o   = master_read_i & is_apb;
    assign bridge_write_o  = master_write_i & is_apb;

    always_comb begin
        master_stall_o  = 1'b0;
        master_rddata_o = '0;   // unmapped reads return 0
        case (region)
            soc_bus_pkg::REGION_RAM: begin
                master_stall_o  = ram_rd;
                master_rddata_o = ram.rdata;
            end
            soc_bus_pkg::REGION_GPIO, soc_bus_pkg::REGION_TICKER: begin
                master_stall_o  = bridge_stall_i;
                master_rddata_o = bridge_rdata_i;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- source/data_ram.sv
`default_nettype none

module data_ram #(
    parameter int RAM_ADDR_BITS = 8,
    parameter int DATA_W        = 32
) (
    input  wire clk,
    input  wire rst_n,
    ram_if.mem  ram
);

    localparam int WORDS = 2 ** RAM_ADDR_BITS;
    localparam int LANES = DATA_W / 8;

    logic [DATA_W-1:0] mem [WORDS];
    logic [DATA_W-1:0] rdata_q;

    // byte lane writes
    always_ff @(posedge clk) begin
        if (ram.wr) begin
            for (int i = 0; i < LANES; i++) begin
                if (ram.be[i]) begin
                    mem[ram.addr][8*i +: 8] <= ram.wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (ram.rd) begin
            rdata_q <= mem[ram.addr];   // valid the cycle after rd
        end
    end

    assign ram.rdata = rdata_q;

endmodule

`default_nettype wire

//--- source/apb_bridge.sv
`default_nettype none

module apb_bridge (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire soc_bus_pkg::region_e       region_i,
    input  wire                             read_i,
    input  wire                             write_i,
    input  wire [soc_bus_pkg::ADDR_W-1:0]   address_i,
    input  wire [soc_bus_pkg::DATA_W-1:0]   wdata_i,
    input  wire [soc_bus_pkg::BE_W-1:0]     be_i,
    output logic [soc_bus_pkg::DATA_W-1:0]  rdata_o,
    output logic                            stall_o,
    apb_if.master                           gpio_apb,
    apb_if.master                           tick_apb
);

    soc_apb_pkg::apb_state_e state_q;
    soc_apb_pkg::apb_state_e state_d;
    soc_apb_pkg::apb_state_e phase;     // state seen on the bus this cycle

    logic req;
    logic sel_gpio;
    logic busy;
    logic pready;
    logic [soc_apb_pkg::APB_ADDR_W-1:0] paddr;
    logic [soc_bus_pkg::BE_W-1:0]       pstrb;
    logic [soc_bus_pkg::DATA_W-1:0]     rdata_q;

    assign req      = read_i | write_i;
    assign sel_gpio = (region_i == soc_bus_pkg::REGION_GPIO);

    // a new request starts its setup phase in the same cycle
    always_comb begin
        if (state_q == soc_apb_pkg::APB_IDLE && req) begin
            phase = soc_apb_pkg::APB_SETUP;
        end else begin
            phase = state_q;
        end
    end

    assign pready = sel_gpio ? gpio_apb.pready : tick_apb.pready;

    always_comb begin
        case (phase)
            soc_apb_pkg::APB_SETUP:  state_d = soc_apb_pkg::APB_ACCESS;
            soc_apb_pkg::APB_ACCESS: begin
                state_d = pready ? soc_apb_pkg::APB_DONE : soc_apb_pkg::APB_ACCESS;
            end
            default:                 state_d = soc_apb_pkg::APB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= soc_apb_pkg::APB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (phase == soc_apb_pkg::APB_ACCESS && pready) begin
            rdata_q <= sel_gpio ? gpio_apb.prdata : tick_apb.prdata;
        end
    end

    assign busy    = (phase == soc_apb_pkg::APB_SETUP) || (phase == soc_apb_pkg::APB_ACCESS);
    assign stall_o = busy;
    assign rdata_o = rdata_q;   // read by the master in DONE

    assign paddr = address_i[soc_apb_pkg::APB_ADDR_W-1:0];
    assign pstrb = write_i ? be_i : '0;

    assign gpio_apb.paddr   = paddr;
    assign gpio_apb.psel    = busy & sel_gpio;
    assign gpio_apb.penable = (phase == soc_apb_pkg::APB_ACCESS);
    assign gpio_apb.pwrite  = write_i;
    assign gpio_apb.pwdata  = wdata_i;
    assign gpio_apb.pstrb   = pstrb;

    assign tick_apb.paddr   = paddr;
    assign tick_apb.psel    = busy & ~sel_gpio;
    assign tick_apb.penable = (phase == soc_apb_pkg::APB_ACCESS);
    assign tick_apb.pwrite  = write_i;
    assign tick_apb.pwdata  = wdata_i;
    assign tick_apb.pstrb   = pstrb;

endmodule

`default_nettype wire

//--- source/gpio_regs.sv
`default_nettype none

module gpio_regs #(
    parameter int DATA_W = 32
) (
    input  wire                 clk,
    input  wire                 rst_n,
    apb_if.slave                apb,
    input  wire [DATA_W-1:0]    gpio_i,
    output logic [DATA_W-1:0]   gpio_o
);

    logic [DATA_W-1:0] out_q;
    logic [DATA_W-1:0] sync1_q;
    logic [DATA_W-1:0] sync2_q;
    logic              wr_en;

    assign wr_en = apb.psel & apb.penable & apb.pwrite;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_q <= '0;
        end else if (wr_en && apb.paddr == soc_apb_pkg::GPIO_OUT_OFS) begin
            for (int i = 0; i < DATA_W / 8; i++) begin
                if (apb.pstrb[i]) begin
                    out_q[8*i +: 8] <= apb.pwdata[8*i +: 8];
                end
            end
        end
    end

    // two flop input sync
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= gpio_i;
            sync2_q <= sync1_q;
        end
    end

    always_comb begin
        case (apb.paddr)
            soc_apb_pkg::GPIO_OUT_OFS: apb.prdata = out_q;
            soc_apb_pkg::GPIO_IN_OFS:  apb.prdata = sync2_q;
            default:                   apb.prdata = '0;
        endcase
    end

    assign apb.pready = 1'b1;
    assign gpio_o     = out_q;

endmodule

`default_nettype wire

//--- source/ticker.sv
`default_nettype none

module ticker #(
    parameter int DATA_W = 32
) (
    input  wire     clk,
    input  wire     rst_n,
    apb_if.slave    apb,
    output logic    irq_o
);

    logic [DATA_W-1:0] count_q;
    logic [DATA_W-1:0] cmp_q;
    logic              flag_q;
    logic              wr_en;
    logic              hit;

    assign wr_en = apb.psel & apb.penable & apb.pwrite;
    assign hit   = (cmp_q != '0) && (count_q == cmp_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
            cmp_q   <= '0;
            flag_q  <= 1'b0;
        end else begin
            count_q <= count_q + 1'b1;  // free running
            if (wr_en && apb.paddr == soc_apb_pkg::TICK_CMP_OFS) begin
                for (int i = 0; i < DATA_W / 8; i++) begin
                    if (apb.pstrb[i]) begin
                        cmp_q[8*i +: 8] <= apb.pwdata[8*i +: 8];
                    end
                end
            end
            // a fresh match beats a clear in the same cycle
            if (hit) begin
                flag_q <= 1'b1;
            end else if (wr_en && apb.paddr == soc_apb_pkg::TICK_STAT_OFS) begin
                flag_q <= 1'b0;
            end
        end
    end

    always_comb begin
        case (apb.paddr)
            soc_apb_pkg::TICK_COUNT_OFS: apb.prdata = count_q;
            soc_apb_pkg::TICK_CMP_OFS:   apb.prdata = cmp_q;
            soc_apb_pkg::TICK_STAT_OFS:  apb.prdata = {{(DATA_W-1){1'b0}}, flag_q};
            default:                     apb.prdata = '0;
        endcase
    end

    assign apb.pready = 1'b1;
    assign irq_o      = flag_q;

endmodule

`default_nettype wire

//--- source/soc_bus_top.sv
`default_nettype none

module soc_bus_top #(
    parameter int RAM_ADDR_BITS = 8     // up to 26
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire [soc_bus_pkg::ADDR_W-1:0]   master_address_i,
    input  wire [soc_bus_pkg::BE_W-1:0]     master_byteenable_i,
    input  wire                             master_read_i,
    input  wire                             master_write_i,
    input  wire [soc_bus_pkg::DATA_W-1:0]   master_wrdata_i,
    output logic [soc_bus_pkg::DATA_W-1:0]  master_rddata_o,
    output logic                            master_stall_o,
    input  wire [31:0]                      gpio_i,
    output logic [31:0]                     gpio_o,
    output logic                            irq_o
);

    logic [soc_bus_pkg::DATA_W-1:0] bridge_rdata;
    logic                           bridge_stall;
    soc_bus_pkg::region_e           bridge_region;
    logic                           bridge_read;
    logic                           bridge_write;

    ram_if #(.ADDR_BITS(RAM_ADDR_BITS), .DATA_W(soc_bus_pkg::DATA_W)) ram_bus ();
    apb_if #(.DATA_W(soc_bus_pkg::DATA_W)) gpio_apb ();
    apb_if #(.DATA_W(soc_bus_pkg::DATA_W)) tick_apb ();

    dbus_decoder #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_decoder (
        .clk                 (clk),
        .rst_n               (rst_n),
        .master_address_i    (master_address_i),
        .master_byteenable_i (master_byteenable_i),
        .master_read_i       (master_read_i),
        .master_write_i      (master_write_i),
        .master_wrdata_i     (master_wrdata_i),
        .master_rddata_o     (master_rddata_o),
        .master_stall_o      (master_stall_o),
        .bridge_rdata_i      (bridge_rdata),
        .bridge_stall_i      (bridge_stall),
        .bridge_region_o     (bridge_region),
        .bridge_read_o       (bridge_read),
        .bridge_write_o      (bridge_write),
        .ram                 (ram_bus.ctrl)
    );

    data_ram #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS),
        .DATA_W        (soc_bus_pkg::DATA_W)
    ) u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .ram   (ram_bus.mem)
    );

    // address and data go to the bridge straight from the master
    apb_bridge u_bridge (
        .clk       (clk),
        .rst_n     (rst_n),
        .region_i  (bridge_region),
        .read_i    (bridge_read),
        .write_i   (bridge_write),
        .address_i (master_address_i),
        .wdata_i   (master_wrdata_i),
        .be_i      (master_byteenable_i),
        .rdata_o   (bridge_rdata),
        .stall_o   (bridge_stall),
        .gpio_apb  (gpio_apb.master),
        .tick_apb  (tick_apb.master)
    );

    gpio_regs #(.DATA_W(soc_bus_pkg::DATA_W)) u_gpio (
        .clk    (clk),
        .rst_n  (rst_n),
        .apb    (gpio_apb.slave),
        .gpio_i (gpio_i),
        .gpio_o (gpio_o)
    );

    ticker #(.DATA_W(soc_bus_pkg::DATA_W)) u_ticker (
        .clk   (clk),
        .rst_n (rst_n),
        .apb   (tick_apb.slave),
        .irq_o (irq_o)
    );

endmodule

`default_nettype wire

//--- tb/tb_soc_bus_model.svh
`ifndef TB_SOC_BUS_MODEL_SVH
`define TB_SOC_BUS_MODEL_SVH

// state the DUT should hold after each completed write
logic [31:0] model_ram [RAM_WORDS];
logic [31:0] model_gpio_out = '0;
logic [31:0] model_tick_cmp = '0;

function automatic logic [31:0] merge_bytes(input logic [31:0] old_v,
                                            input logic [31:0] new_v,
                                            input logic [3:0]  be);
    logic [31:0] v;
    v = old_v;
    for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
            v[8*i +: 8] = new_v[8*i +: 8];
        end
    end
    return v;
endfunction

function automatic int ram_word(input logic [31:0] addr);
    return int'(addr[RAM_ADDR_BITS+1:2]);   // byte address to word index
endfunction

task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    case (addr[31:28])
        soc_bus_pkg::REGION_RAM_BASE: begin
            model_ram[ram_word(addr)] = merge_bytes(model_ram[ram_word(addr)], data, be);
        end
        soc_bus_pkg::REGION_GPIO_BASE: begin
            if (addr[7:0] == soc_apb_pkg::GPIO_OUT_OFS) begin
                model_gpio_out = merge_bytes(model_gpio_out, data, be);
            end
        end
        soc_bus_pkg::REGION_TICKER_BASE: begin
            if (addr[7:0] == soc_apb_pkg::TICK_CMP_OFS) begin
                model_tick_cmp = merge_bytes(model_tick_cmp, data, be);
            end
        end
        default: ;  // unmapped writes are dropped
    endcase
endtask

// only for RAM, GPIO_OUT, TICK_CMP and unmapped reads
function automatic logic [31:0] model_read(input logic [31:0] addr);
    case (addr[31:28])
        soc_bus_pkg::REGION_RAM_BASE:    return model_ram[ram_word(addr)];
        soc_bus_pkg::REGION_GPIO_BASE:   return model_gpio_out;
        soc_bus_pkg::REGION_TICKER_BASE: return model_tick_cmp;
        default:                         return 32'h0;
    endcase
endfunction

function automatic int expected_stalls(input logic [31:0] addr, input logic wr);
    case (addr[31:28])
        soc_bus_pkg::REGION_RAM_BASE:    return wr ? 0 : 1;
        soc_bus_pkg::REGION_GPIO_BASE:   return 2;   // apb setup + access
        soc_bus_pkg::REGION_TICKER_BASE: return 2;
        default:                         return 0;
    endcase
endfunction

`endif

//--- tb/tb_soc_bus.sv
`default_nettype none

module tb_soc_bus;

    localparam int RAM_ADDR_BITS = 8;
    localparam int RAM_WORDS     = 2 ** RAM_ADDR_BITS;
    localparam int STALL_LIMIT   = 20;
    localparam int IRQ_LIMIT     = 100;

    localparam logic [31:0] GPIO_BASE = {soc_bus_pkg::REGION_GPIO_BASE, 28'h0};
    localparam logic [31:0] TICK_BASE = {soc_bus_pkg::REGION_TICKER_BASE, 28'h0};

    logic        clk;
    logic        rst_n;
    logic [31:0] master_address;
    logic [3:0]  master_byteenable;
    logic        master_read;
    logic        master_write;
    logic [31:0] master_wrdata;
    logic [31:0] master_rddata;
    logic        master_stall;
    logic [31:0] gpio_in;
    logic [31:0] gpio_out;
    logic        irq;

    logic [31:0] lfsr = 32'h9a26fb30;
    int          errors = 0;
    int          cycle = 0;
    int          done_cycle = 0;   // cycle in which the last access completed

    `include "tb_soc_bus_model.svh"

    soc_bus_top #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) dut_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .master_address_i    (master_address),
        .master_byteenable_i (master_byteenable),
        .master_read_i       (master_read),
        .master_write_i      (master_write),
        .master_wrdata_i     (master_wrdata),
        .master_rddata_o     (master_rddata),
        .master_stall_o      (master_stall),
        .gpio_i              (gpio_in),
        .gpio_o              (gpio_out),
        .irq_o               (irq)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch at time %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic abort_run(input string why);
        errors++;
        $display("Timeout at time %0t: %s", $time, why);
        $display("errors: %0d", errors);
        $display("RESULT: FAIL");
        $finish;
    endtask

    // drive one access and hold it until stall drops
    task automatic bus_cycle(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] be, output logic [31:0] rdata);
        int stalls;
        @(posedge clk);
        #5;
        master_address    = addr;
        master_byteenable = be;
        master_wrdata     = wdata;
        master_read       = ~wr;
        master_write      = wr;
        stalls = 0;
        @(negedge clk);
        while (master_stall) begin
            stalls++;
            if (stalls > STALL_LIMIT) begin
                abort_run("master_stall_o stayed high past the access timeout");
            end
            @(negedge clk);
        end
        rdata      = master_rddata;
        done_cycle = cycle;
        check_value("stall cycles", 32'(expected_stalls(addr, wr)), 32'(stalls));
        @(posedge clk);
        #5;
        master_read  = 1'b0;
        master_write = 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] be);
        logic [31:0] unused;
        bus_cycle(1'b1, addr, data, be, unused);
        model_write(addr, data, be);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        bus_cycle(1'b0, addr, 32'h0, 4'hf, data);
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rd;
        logic [31:0] c1;
        logic [31:0] c2;
        logic [3:0]  be;
        logic [3:0]  nib;
        int          d1;
        int          wait_n;

        clk               = 1'b0;
        rst_n             = 1'b0;
        master_address    = '0;
        master_byteenable = '0;
        master_read       = 1'b0;
        master_write      = 1'b0;
        master_wrdata     = '0;
        gpio_in           = '0;
        repeat (10) @(posedge clk);
        #5 rst_n = 1'b1;

        // fill every word so later reads are defined
        for (int i = 0; i < RAM_WORDS; i++) begin
            bus_write(32'(i) << 2, take_bits(32), 4'hf);
        end
        repeat (200) begin
            addr = {4'h0, 26'(take_bits(26)), 2'b00};
            if (take_bits(1)) begin
                be = 4'(take_bits(4));
                bus_write(addr, take_bits(32), be);
            end else begin
                bus_read(addr, rd);
                check_value("master_rddata_o (ram)", model_read(addr), rd);
            end
        end

        repeat (20) begin
            be = 4'(take_bits(4));
            bus_write(GPIO_BASE | soc_apb_pkg::GPIO_OUT_OFS, take_bits(32), be);
            check_value("gpio_o", model_gpio_out, gpio_out);
            bus_read(GPIO_BASE | soc_apb_pkg::GPIO_OUT_OFS, rd);
            check_value("GPIO_OUT readback", model_gpio_out, rd);
        end

        repeat (8) begin
            data    = take_bits(32);
            gpio_in = data;
            repeat (4) @(posedge clk);
            bus_read(GPIO_BASE | soc_apb_pkg::GPIO_IN_OFS, rd);
            check_value("GPIO_IN", data, rd);
        end

        bus_read(TICK_BASE | soc_apb_pkg::TICK_COUNT_OFS, c1);
        d1 = done_cycle;
        repeat (take_bits(4) + 3) @(posedge clk);
        bus_read(TICK_BASE | soc_apb_pkg::TICK_COUNT_OFS, c2);
        if (c2 <= c1) begin
            errors++;
            $display("Error at time %0t: ticker count did not increase (%h then %h)",
                     $time, c1, c2);
        end else if (int'(c2 - c1) < done_cycle - d1) begin
            errors++;
            $display("Error at time %0t: ticker advanced %0d over %0d cycles",
                     $time, c2 - c1, done_cycle - d1);
        end

        bus_read(TICK_BASE | soc_apb_pkg::TICK_COUNT_OFS, c1);
        bus_write(TICK_BASE | soc_apb_pkg::TICK_CMP_OFS, c1 + 40, 4'hf);
        wait_n = 0;
        while (!irq) begin
            @(negedge clk);
            wait_n++;
            if (wait_n > IRQ_LIMIT) begin
                abort_run("irq_o never rose after the compare was set");
            end
        end
        bus_read(TICK_BASE | soc_apb_pkg::TICK_STAT_OFS, rd);
        check_value("TICK_STAT", 32'h1, rd);
        bus_write(TICK_BASE | soc_apb_pkg::TICK_STAT_OFS, 32'h0, 4'hf);
        check_value("irq_o", 32'h0, 32'(irq));
        bus_write(TICK_BASE | soc_apb_pkg::TICK_CMP_OFS, 32'h0, 4'hf);
        bus_read(TICK_BASE | soc_apb_pkg::TICK_CMP_OFS, rd);
        check_value("TICK_CMP", model_tick_cmp, rd);

        repeat (40) begin
            nib  = 4'(3 + take_bits(4) % 13);   // top nibble 3..15
            addr = {nib, 28'(take_bits(28))};
            if (take_bits(1)) begin
                be = 4'(take_bits(4));
                bus_write(addr, take_bits(32), be);
            end else begin
                bus_read(addr, rd);
                check_value("master_rddata_o (unmapped)", 32'h0, rd);
            end
        end
        check_value("gpio_o", model_gpio_out, gpio_out);
        for (int i = 0; i < RAM_WORDS; i++) begin
            bus_read(32'(i) << 2, rd);
            check_value("master_rddata_o (ram)", model_ram[i], rd);
        end

        // counter restarts at 0 with the compare at 0
        @(posedge clk);
        #5 rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #5 rst_n = 1'b1;
        check_value("gpio_o", 32'h0, gpio_out);
        repeat (50) begin
            @(negedge clk);
            check_value("irq_o", 32'h0, 32'(irq));
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+tb
source/soc_bus_pkg.sv
source/soc_apb_pkg.sv
source/apb_if.sv
source/ram_if.sv
source/dbus_decoder.sv
source/data_ram.sv
source/apb_bridge.sv
source/gpio_regs.sv
source/ticker.sv
source/soc_bus_top.sv
tb/tb_soc_bus.sv

//--- Bender.yml
package:
  name: soc_bus

sources:
  - source/soc_bus_pkg.sv
  - source/soc_apb_pkg.sv
  - source/apb_if.sv
  - source/ram_if.sv
  - source/dbus_decoder.sv
  - source/data_ram.sv
  - source/apb_bridge.sv
  - source/gpio_regs.sv
  - source/ticker.sv
  - source/soc_bus_top.sv

  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_soc_bus.sv
